// File: logic/chen_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chen oscillator build settings
// word format, credit depth, system constants and initial point
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CHEN_SETTINGS_SVH
`define CHEN_SETTINGS_SVH

// A(11,20) two's complement word
`define CHEN_WIDTH 32
`define CHEN_FRAC 20

// credits granted at reset, also the ceiling
`define CHEN_CREDITS 4

// sample index width
`define CHEN_IDX_W 16

// a = 35, b = 3, c = 28
`define CHEN_A 32'sh0230_0000
`define CHEN_B 32'sh0030_0000
`define CHEN_C 32'sh01C0_0000

// h = 2^-8
`define CHEN_H 32'sh0000_1000

// initial point (-10, 0, 37)
`define CHEN_X0 32'shFF60_0000
`define CHEN_Y0 32'sh0000_0000
`define CHEN_Z0 32'sh0250_0000

`endif

// File: logic/chen_fixed_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-point word type and multiply for the Chen oscillator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "chen_settings.svh"

package chen_fixed_pkg;

  // signed A(11,20) word
  typedef logic signed [`CHEN_WIDTH-1:0] fx_t;

  // full product, arithmetic shift by the fraction width,
  // then keep the low word (wraps, no saturation)
  function automatic fx_t fx_mul(input fx_t a, input fx_t b);
    logic signed [2*`CHEN_WIDTH-1:0] prod;
    logic signed [2*`CHEN_WIDTH-1:0] shifted;
    prod = (2*`CHEN_WIDTH)'(a) * (2*`CHEN_WIDTH)'(b);
    shifted = prod >>> `CHEN_FRAC;
    return shifted[`CHEN_WIDTH-1:0];
  endfunction

endpackage

// File: logic/chen_stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// State, derivative and sample records of the Chen oscillator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "chen_settings.svh"

package chen_stream_pkg;

  import chen_fixed_pkg::*;

  typedef struct packed {
    fx_t x;
    fx_t y;
    fx_t z;
  } chen_state_t;

  typedef struct packed {
    fx_t dx;
    fx_t dy;
    fx_t dz;
  } chen_deriv_t;

  // one output sample, index counts steps since load
  typedef struct packed {
    logic [`CHEN_IDX_W-1:0] idx;
    chen_state_t            state;
  } chen_sample_t;

endpackage

// File: logic/chen_step_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chen step control
// run flag and consumer credit counter, decides load and step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "chen_settings.svh"

module chen_step_ctrl (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic stop_i,
  input  logic credit_return_i,
  output logic load_o,
  output logic step_o,
  output logic busy_o
);

  localparam int CNT_W = $clog2(`CHEN_CREDITS + 1);

  logic             run_q;
  logic [CNT_W-1:0] cnt_q;
  logic             credit_ok;

  // a credit coming back this cycle can be spent right away
  assign credit_ok = (cnt_q != '0) || credit_return_i;

  assign load_o = start_i;
  assign step_o = run_q && !start_i && !stop_i && credit_ok;
  assign busy_o = run_q;

  // start wins over stop
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q <= 1'b0;
    end else if (start_i) begin
      run_q <= 1'b1;
    end else if (stop_i) begin
      run_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= CNT_W'(`CHEN_CREDITS);
    end else begin
      cnt_q <= cnt_q + CNT_W'(credit_return_i) - CNT_W'(step_o);
    end
  end

  a_cnt_max: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cnt_q <= CNT_W'(`CHEN_CREDITS)
  );

  // consumer returned a credit it never held
  a_return_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    credit_return_i |-> cnt_q != CNT_W'(`CHEN_CREDITS)
  );

endmodule

// File: logic/chen_flow_xy.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chen x/y flow terms
// dx = a(y - x), dy = (c - a)x - xz + cy, purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "chen_settings.svh"

module chen_flow_xy
  import chen_fixed_pkg::*;
  import chen_stream_pkg::*;
(
  input  chen_state_t state_i,
  output fx_t         dx_o,
  output fx_t         dy_o
);

  localparam fx_t A_FX = `CHEN_A;
  localparam fx_t C_FX = `CHEN_C;
  // c - a folded at elaboration
  localparam fx_t C_MINUS_A_FX = C_FX - A_FX;

  fx_t y_minus_x;
  fx_t cma_x;
  fx_t x_z;
  fx_t c_y;

  assign y_minus_x = state_i.y - state_i.x;

  // x derivative
  assign dx_o = fx_mul(A_FX, y_minus_x);

  // y derivative terms
  assign cma_x = fx_mul(C_MINUS_A_FX, state_i.x);
  assign x_z   = fx_mul(state_i.x, state_i.z);
  assign c_y   = fx_mul(C_FX, state_i.y);

  assign dy_o = cma_x - x_z + c_y;

endmodule

// File: logic/chen_flow_z.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chen z flow term, dz = xy - bz, combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "chen_settings.svh"

module chen_flow_z
  import chen_fixed_pkg::*;
  import chen_stream_pkg::*;
(
  input  chen_state_t state_i,
  output fx_t         dz_o
);

  localparam fx_t B_FX = `CHEN_B;

  fx_t x_y;
  fx_t b_z;

  assign x_y = fx_mul(state_i.x, state_i.y);
  assign b_z = fx_mul(B_FX, state_i.z);

  assign dz_o = x_y - b_z;

endmodule

// File: logic/chen_euler_update.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chen forward Euler integrator
// state registers, step index and the output sample register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "chen_settings.svh"

module chen_euler_update
  import chen_fixed_pkg::*;
  import chen_stream_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         load_i,
  input  logic         step_i,
  input  chen_deriv_t  deriv_i,
  output chen_state_t  state_o,
  output logic         sample_valid_o,
  output chen_sample_t sample_o
);

  localparam fx_t H_FX = `CHEN_H;

  chen_state_t            state_q;
  chen_state_t            next_state;
  logic [`CHEN_IDX_W-1:0] idx_q;
  logic [`CHEN_IDX_W-1:0] next_idx;
  chen_sample_t           sample_q;
  logic                   valid_q;

  // x_{n+1} = x_n + h * f(x_n)
  always_comb begin
    next_state.x = state_q.x + fx_mul(deriv_i.dx, H_FX);
    next_state.y = state_q.y + fx_mul(deriv_i.dy, H_FX);
    next_state.z = state_q.z + fx_mul(deriv_i.dz, H_FX);
  end

  assign next_idx = idx_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      state_q <= '{x: `CHEN_X0, y: `CHEN_Y0, z: `CHEN_Z0};
    end else if (step_i) begin
      state_q <= next_state;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idx_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= step_i && !load_i;
      if (load_i) begin
        idx_q <= '0;
      end else if (step_i) begin
        idx_q <= next_idx;
      end
    end
  end

  // sample carries the freshly stepped state
  always_ff @(posedge clk_i) begin
    if (step_i) begin
      sample_q <= '{idx: next_idx, state: next_state};
    end
  end

  assign state_o        = state_q;
  assign sample_valid_o = valid_q;
  assign sample_o       = sample_q;

endmodule

// File: logic/chen_oscillator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chen chaotic oscillator top
// credit flow controlled stream of Euler integrated samples
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module chen_oscillator
  import chen_fixed_pkg::*;
  import chen_stream_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         start_i,
  input  logic         stop_i,
  input  logic         credit_return_i,
  output logic         sample_valid_o,
  output chen_sample_t sample_o,
  output logic         busy_o
);

  logic        load;
  logic        step;
  chen_state_t state;
  fx_t         dx;
  fx_t         dy;
  fx_t         dz;
  chen_deriv_t deriv;

  assign deriv = '{dx: dx, dy: dy, dz: dz};

  chen_step_ctrl ctrl_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .start_i         (start_i),
    .stop_i          (stop_i),
    .credit_return_i (credit_return_i),
    .load_o          (load),
    .step_o          (step),
    .busy_o          (busy_o)
  );

  // x/y and z terms evaluated side by side
  chen_flow_xy flow_xy_inst (
    .state_i (state),
    .dx_o    (dx),
    .dy_o    (dy)
  );

  chen_flow_z flow_z_inst (
    .state_i (state),
    .dz_o    (dz)
  );

  chen_euler_update euler_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .load_i         (load),
    .step_i         (step),
    .deriv_i        (deriv),
    .state_o        (state),
    .sample_valid_o (sample_valid_o),
    .sample_o       (sample_o)
  );

endmodule

// File: tb/chen_oscillator_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chen oscillator testbench
// directed tests against an Euler reference model with a credit consumer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "chen_settings.svh"

module chen_oscillator_tb
  import chen_fixed_pkg::*;
  import chen_stream_pkg::*;
();

  localparam int MODE_IMMEDIATE = 0;
  localparam int MODE_HOLD      = 1;
  localparam int MODE_RANDOM    = 2;
  localparam int RANDOM_SAMPLES = 40;
  // cycles for reset, full rate, held/random credits, restart and stop/start
  localparam int TEST_CYCLES = 10 + 70 + (30 + RANDOM_SAMPLES * 9) + 30 + 50;
  localparam int MAX_CYCLES  = TEST_CYCLES + 200;
  localparam chen_state_t INIT_STATE = '{x: `CHEN_X0, y: `CHEN_Y0, z: `CHEN_Z0};

  logic         clk_i;
  logic         arst_n_i;
  logic         start_i;
  logic         stop_i;
  logic         credit_return_i;
  logic         sample_valid_o;
  chen_sample_t sample_o;
  logic         busy_o;

  chen_state_t            model_state;
  logic [`CHEN_IDX_W-1:0] model_idx;
  chen_sample_t           last_sample;
  int sample_count = 0;
  int credits_returned = 0;
  int credit_mode = MODE_IMMEDIATE;
  int value_errors = 0;
  int protocol_errors = 0;
  int cycle_count = 0;
  int seed = 32'h6496_a7a6;

  chen_oscillator chen_oscillator_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .start_i         (start_i),
    .stop_i          (stop_i),
    .credit_return_i (credit_return_i),
    .sample_valid_o  (sample_valid_o),
    .sample_o        (sample_o),
    .busy_o          (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // full product, arithmetic shift, low word kept
  function automatic fx_t ref_mul(input fx_t a, input fx_t b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return fx_t'(prod >>> `CHEN_FRAC);
  endfunction

  // one forward Euler step of the Chen system
  task automatic advance_model(input chen_state_t cur, output chen_state_t nxt);
    fx_t dx;
    fx_t dy;
    fx_t dz;
    dx = ref_mul(`CHEN_A, cur.y - cur.x);
    dy = ref_mul(`CHEN_C - `CHEN_A, cur.x) - ref_mul(cur.x, cur.z) + ref_mul(`CHEN_C, cur.y);
    dz = ref_mul(cur.x, cur.y) - ref_mul(`CHEN_B, cur.z);
    nxt.x = cur.x + ref_mul(dx, `CHEN_H);
    nxt.y = cur.y + ref_mul(dy, `CHEN_H);
    nxt.z = cur.z + ref_mul(dz, `CHEN_H);
  endtask

  task automatic compare_state(input string name, input chen_state_t exp, input chen_state_t act);
    if (exp !== act) begin
      value_errors++;
      $display("error t=%0t %s expected x=%h y=%h z=%h actual x=%h y=%h z=%h",
               $time, name, exp.x, exp.y, exp.z, act.x, act.y, act.z);
    end
  endtask

  task automatic compare_index(input string name, input logic [`CHEN_IDX_W-1:0] exp,
                               input logic [`CHEN_IDX_W-1:0] act);
    if (exp !== act) begin
      value_errors++;
      $display("error t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      value_errors++;
      $display("error t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // an old-sequence sample is checked before a restart takes effect
  always @(negedge clk_i) begin
    chen_state_t nxt;
    if (arst_n_i && sample_valid_o) begin
      advance_model(model_state, nxt);
      model_state = nxt;
      model_idx = model_idx + 1'b1;
      compare_index("sample_o.idx", model_idx, sample_o.idx);
      compare_state("sample_o.state", model_state, sample_o.state);
      last_sample = sample_o;
      sample_count++;
      if (sample_count - credits_returned > `CHEN_CREDITS) begin
        protocol_errors++;
        $display("more samples outstanding than credits granted at t=%0t", $time);
      end
    end
    if (start_i) begin
      model_state = INIT_STATE;
      model_idx = '0;
    end
  end

  // consumer credit returns
  initial begin
    int delay_left;
    int r;
    delay_left = 0;
    credit_return_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (sample_count > credits_returned && credit_mode != MODE_HOLD && delay_left == 0) begin
        credit_return_i <= 1'b1;
        credits_returned++;
        if (credit_mode == MODE_RANDOM) begin
          r = $random(seed);
          delay_left = r & 7;
        end
      end else begin
        credit_return_i <= 1'b0;
        if (delay_left > 0) begin
          delay_left--;
        end
      end
    end
  end

  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic start_run();
    @(posedge clk_i);
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  task automatic stop_run();
    @(posedge clk_i);
    stop_i <= 1'b1;
    @(posedge clk_i);
    stop_i <= 1'b0;
  endtask

  task automatic wait_samples(input int target, input int limit);
    int waited;
    waited = 0;
    while (sample_count < target && waited < limit) begin
      @(posedge clk_i);
      waited++;
    end
    if (sample_count < target) begin
      protocol_errors++;
      $display("missing samples, %0d of %0d arrived", sample_count, target);
    end
  endtask

  // wait until every sample has its credit back
  task automatic drain_credits();
    int waited;
    waited = 0;
    while (sample_count != credits_returned && waited < 50) begin
      @(posedge clk_i);
      waited++;
    end
    if (sample_count != credits_returned) begin
      protocol_errors++;
      $display("credits were not all returned");
    end
    repeat (3) @(posedge clk_i);
  endtask

  task automatic test_reset_idle();
    repeat (5) begin
      @(negedge clk_i);
      compare_bit("sample_valid_o", 1'b0, sample_valid_o);
      compare_bit("busy_o", 1'b0, busy_o);
    end
    start_run();
    @(negedge clk_i);
    compare_bit("busy_o", 1'b1, busy_o);
  endtask

  task automatic test_full_rate();
    int base;
    credit_mode <= MODE_IMMEDIATE;
    start_run();
    base = sample_count;
    wait_samples(base + 64, 70);
    compare_index("sample_o.idx", 16'd64, last_sample.idx);
  endtask

  task automatic test_credit_hold();
    int base;
    stop_run();
    drain_credits();
    credit_mode <= MODE_HOLD;
    start_run();
    base = sample_count;
    repeat (20) @(posedge clk_i);
    if (sample_count - base != `CHEN_CREDITS) begin
      protocol_errors++;
      $display("credits held back, expected %0d samples but got %0d",
               `CHEN_CREDITS, sample_count - base);
    end
    @(negedge clk_i);
    compare_bit("sample_valid_o", 1'b0, sample_valid_o);
    credit_mode <= MODE_RANDOM;
    wait_samples(base + RANDOM_SAMPLES, RANDOM_SAMPLES * 9);
    compare_index("sample_o.idx", 16'(RANDOM_SAMPLES), last_sample.idx);
  endtask

  task automatic test_restart();
    int base;
    chen_state_t first;
    credit_mode <= MODE_IMMEDIATE;
    wait_samples(sample_count + 10, 30);
    start_run();
    base = sample_count;
    wait_samples(base + 1, 10);
    advance_model(INIT_STATE, first);
    compare_index("sample_o.idx", 16'd1, last_sample.idx);
    compare_state("sample_o.state", first, last_sample.state);
  endtask

  task automatic test_stop_start();
    int base;
    stop_run();
    // a step in the stop cycle would show up from here on
    base = sample_count;
    @(negedge clk_i);
    compare_bit("busy_o", 1'b0, busy_o);
    drain_credits();
    repeat (10) @(posedge clk_i);
    if (sample_count != base) begin
      protocol_errors++;
      $display("unexpected sample after stop");
    end
    start_run();
    base = sample_count;
    wait_samples(base + 16, 25);
    compare_index("sample_o.idx", 16'd16, last_sample.idx);
  endtask

  initial begin
    arst_n_i = 1'b0;
    start_i = 1'b0;
    stop_i = 1'b0;
    model_state = INIT_STATE;
    model_idx = '0;
    last_sample = '0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    test_reset_idle();
    test_full_rate();
    test_credit_hold();
    test_restart();
    test_stop_start();
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
logic/chen_fixed_pkg.sv
logic/chen_stream_pkg.sv
logic/chen_step_ctrl.sv
logic/chen_flow_xy.sv
logic/chen_flow_z.sv
logic/chen_euler_update.sv
logic/chen_oscillator.sv
tb/chen_oscillator_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Chen oscillator testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=chen_oscillator_tb

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f project.f -Mdir "$BUILD_DIR" -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG_FILE"
exit 1
